// ==== Makefile ====
TOP = b2s_rd_tb
LOG = sim.log

.PHONY: all lint clean

all: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q ">>> FAIL" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q ">>> PASS" $(LOG)

obj_dir/V$(TOP): files.f $(wildcard logic/*.sv logic/*.svh verification/*.sv)
	verilator --binary --assert --timescale 1ns/1ps -f files.f --top-module $(TOP)

lint:
	verilator --lint-only -Wall --assert --timescale 1ns/1ps -f files.f --top-module $(TOP)

clean:
	rm -rf obj_dir $(LOG)

// ==== files.f ====
+incdir+logic
logic/axi_types_pkg.sv
logic/b2s_ctrl_pkg.sv
logic/b2s_sync_fifo.sv
logic/b2s_rd_cmd_fsm.sv
logic/b2s_rd_beat_counter.sv
logic/b2s_rd_data_path.sv
logic/b2s_rd_top.sv
verification/b2s_rd_assert.sv
verification/b2s_rd_tb.sv

// ==== logic/axi_types_pkg.sv ====
`default_nettype none

`include "b2s_defines.svh"

package axi_types_pkg;

  // slave read address, one burst
  typedef struct packed {
    logic [`B2S_ADDR_W-1:0] addr;
    logic [7:0]             len;  // beats minus one
    logic [`B2S_ID_W-1:0]   id;
  } s_ar_t;

  // slave read data beat
  typedef struct packed {
    logic [`B2S_DATA_W-1:0] data;
    logic [1:0]             resp;
    logic [`B2S_ID_W-1:0]   id;
    logic                   last;
  } s_r_t;

  // single-beat command to the master side
  typedef struct packed {
    logic [`B2S_ADDR_W-1:0] addr;
  } m_cmd_t;

  // response from the master side
  typedef struct packed {
    logic [`B2S_DATA_W-1:0] data;
    logic [1:0]             resp;
  } m_rsp_t;

endpackage

`default_nettype wire

// ==== logic/b2s_ctrl_pkg.sv ====
`default_nettype none

`include "b2s_defines.svh"

package b2s_ctrl_pkg;

  // command FSM states
  typedef enum logic [1:0] {
    sm_idle         = 2'b00,
    sm_cmd_en       = 2'b01,
    sm_cmd_accepted = 2'b10, // waiting for credits
    sm_done         = 2'b11
  } rd_state_e;

  // one accepted burst, kept until its last R beat leaves
  typedef struct packed {
    logic [`B2S_ID_W-1:0] id;
    logic [7:0]           len;
  } burst_info_t;

endpackage

`default_nettype wire

// ==== logic/b2s_defines.svh ====
`ifndef B2S_DEFINES_SVH
`define B2S_DEFINES_SVH

// ##########################################################
// bus widths
// ##########################################################
`define B2S_DATA_W 32
`define B2S_ADDR_W 32
`define B2S_ID_W 4

// ##########################################################
// buffering
// ##########################################################
`define B2S_DATA_DEPTH 8 // also the credit count
`define B2S_INFO_DEPTH 2

// full-width beats only, so the address steps by the bus width
`define B2S_BEAT_BYTES 4

`endif

// ==== logic/b2s_rd_beat_counter.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "b2s_defines.svh"

module b2s_rd_beat_counter
  import axi_types_pkg::*;
(
  input  wire    clk,
  input  wire    reset,
  input  s_ar_t  s_ar,
  input  wire    a_push,
  input  wire    next,
  output m_cmd_t m_cmd,
  output logic   next_pending
);

  localparam logic [`B2S_ADDR_W-1:0] beat_step = `B2S_BEAT_BYTES;

  logic [`B2S_ADDR_W-1:0] addr_r;
  logic [7:0]             remaining; // beats left after the current one

  // ##########################################################
  // remaining beats
  // ##########################################################
  always_ff @(posedge clk) begin
    if (reset) begin
      remaining <= '0;
    end else if (a_push) begin
      remaining <= s_ar.len;
    end else if (next && remaining != 8'd0) begin
      remaining <= remaining - 8'd1;
    end
  end

  // ##########################################################
  // beat address
  // ##########################################################
  always_ff @(posedge clk) begin
    if (a_push) begin
      addr_r <= s_ar.addr;
    end else if (next) begin
      addr_r <= addr_r + beat_step; // INCR only
    end
  end

  assign m_cmd.addr   = addr_r;
  assign next_pending = (remaining != 8'd0);

endmodule

`default_nettype wire

// ==== logic/b2s_rd_cmd_fsm.sv ====
`timescale 1ns/1ps
`default_nettype none

module b2s_rd_cmd_fsm
  import b2s_ctrl_pkg::*;
(
  input  wire  clk,
  input  wire  reset,
  input  wire  s_arvalid,
  output logic s_arready,
  output logic m_arvalid,
  input  wire  m_arready,
  output logic next,
  input  wire  next_pending,
  input  wire  data_ready,
  output logic a_push,
  output logic r_push
);

  rd_state_e state;
  rd_state_e next_state;

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= sm_idle;
    end else begin
      state <= next_state;
    end
  end

  // ##########################################################
  // next state
  // ##########################################################
  always_comb begin
    next_state = state;
    case (state)
      sm_idle: begin
        if (s_arvalid && data_ready) begin
          next_state = sm_cmd_en;
        end
      end
      sm_cmd_en: begin
        if (m_arready && !next_pending) begin
          next_state = sm_done; // last beat went out
        end else if (m_arready && !data_ready) begin
          next_state = sm_cmd_accepted; // out of credits
        end
      end
      sm_cmd_accepted: begin
        if (data_ready) begin
          next_state = sm_cmd_en;
        end
      end
      sm_done: begin
        next_state = sm_idle;
      end
      default: begin
        next_state = sm_idle;
      end
    endcase
  end

  // ##########################################################
  // outputs
  // ##########################################################
  assign m_arvalid = (state == sm_cmd_en);
  assign next      = m_arready && (state == sm_cmd_en);
  assign r_push    = next;  // each accepted beat takes a credit

  // load counter and tag FIFO only when the burst is taken
  assign a_push    = (state == sm_idle) && s_arvalid && data_ready;

  // burst retires one cycle after its last beat
  assign s_arready = (state == sm_done);

endmodule

`default_nettype wire

// ==== logic/b2s_rd_data_path.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "b2s_defines.svh"

module b2s_rd_data_path
  import axi_types_pkg::*;
  import b2s_ctrl_pkg::*;
(
  input  wire    clk,
  input  wire    reset,
  input  wire    a_push,
  input  s_ar_t  s_ar,
  input  wire    r_push,
  input  m_rsp_t m_rsp,
  input  wire    m_rvalid,
  input  wire    s_rready,
  output logic   data_ready,
  output s_r_t   s_r,
  output logic   s_rvalid
);

  localparam int CW = $clog2(`B2S_DATA_DEPTH + 1);

  m_rsp_t        data_head;
  logic          data_full;
  logic          data_empty;
  burst_info_t   info_in;
  burst_info_t   info_head;
  logic          info_full;
  logic          info_empty;
  logic          r_take;
  logic          r_last;
  logic [7:0]    beat_cnt;   // beats sent of head burst
  logic [CW-1:0] credit_cnt;
  logic [CW-1:0] credit_next;

  // ##########################################################
  // buffers
  // ##########################################################
  assign info_in = '{id: s_ar.id, len: s_ar.len};

  b2s_sync_fifo #(.payload_t(m_rsp_t), .DEPTH(`B2S_DATA_DEPTH)) data_fifo (
    .clk(clk), .reset(reset),
    .push(m_rvalid && !data_full), .din(m_rsp),
    .pop(r_take), .dout(data_head),
    .full(data_full), .empty(data_empty)
  );

  b2s_sync_fifo #(.payload_t(burst_info_t), .DEPTH(`B2S_INFO_DEPTH)) info_fifo (
    .clk(clk), .reset(reset),
    .push(a_push), .din(info_in),
    .pop(r_take && r_last), .dout(info_head), // retire tag on last beat
    .full(info_full), .empty(info_empty)
  );

  // ##########################################################
  // credits
  // ##########################################################
  assign credit_next = credit_cnt - CW'(r_push) + CW'(r_take);

  always_ff @(posedge clk) begin
    if (reset) begin
      credit_cnt <= CW'(`B2S_DATA_DEPTH);
    end else begin
      credit_cnt <= credit_next;
    end
  end

  // also hold off while no room is left for another burst tag
  assign data_ready = (credit_next != '0) && !info_full;

  // ##########################################################
  // slave R tagging
  // ##########################################################
  assign s_rvalid = !data_empty && !info_empty;
  assign r_take   = s_rvalid && s_rready;
  assign r_last   = (beat_cnt == info_head.len);

  always_ff @(posedge clk) begin
    if (reset) begin
      beat_cnt <= '0;
    end else if (r_take) begin
      beat_cnt <= r_last ? 8'd0 : beat_cnt + 8'd1;
    end
  end

  assign s_r = '{data: data_head.data, resp: data_head.resp,
                 id: info_head.id, last: r_last};

endmodule

`default_nettype wire

// ==== logic/b2s_rd_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module b2s_rd_top
  import axi_types_pkg::*;
(
  input  wire    clk,
  input  wire    reset,
  // slave AR
  input  s_ar_t  s_ar,
  input  wire    s_arvalid,
  output logic   s_arready,
  // slave R
  output s_r_t   s_r,
  output logic   s_rvalid,
  input  wire    s_rready,
  // master command
  output m_cmd_t m_cmd,
  output logic   m_arvalid,
  input  wire    m_arready,
  // master response, no ready
  input  m_rsp_t m_rsp,
  input  wire    m_rvalid
);

  logic next;
  logic next_pending;
  logic data_ready;
  logic a_push;
  logic r_push;

  b2s_rd_cmd_fsm fsm0 (
    .clk(clk), .reset(reset),
    .s_arvalid(s_arvalid), .s_arready(s_arready),
    .m_arvalid(m_arvalid), .m_arready(m_arready),
    .next(next), .next_pending(next_pending),
    .data_ready(data_ready),
    .a_push(a_push), .r_push(r_push)
  );

  b2s_rd_beat_counter cnt0 (
    .clk(clk), .reset(reset),
    .s_ar(s_ar), .a_push(a_push), .next(next),
    .m_cmd(m_cmd), .next_pending(next_pending)
  );

  b2s_rd_data_path dp0 (
    .clk(clk), .reset(reset),
    .a_push(a_push), .s_ar(s_ar), .r_push(r_push),
    .m_rsp(m_rsp), .m_rvalid(m_rvalid),
    .s_rready(s_rready), .data_ready(data_ready),
    .s_r(s_r), .s_rvalid(s_rvalid)
  );

endmodule

`default_nettype wire

// ==== logic/b2s_sync_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module b2s_sync_fifo #(
  parameter type payload_t = logic [7:0],
  parameter int  DEPTH     = 4
) (
  input  wire      clk,
  input  wire      reset,
  input  wire      push,
  input  payload_t din,
  input  wire      pop,
  output payload_t dout,
  output logic     full,
  output logic     empty
);

  localparam int PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CW = $clog2(DEPTH + 1);
  localparam logic [PW-1:0] last_ptr = PW'(DEPTH - 1);

  payload_t        mem [DEPTH];
  logic [PW-1:0]   wr_ptr;
  logic [PW-1:0]   rd_ptr;
  logic [CW-1:0]   count;
  logic [CW-1:0]   count_next;
  logic            do_push;
  logic            do_pop;

  assign do_push = push && !full;
  assign do_pop  = pop && !empty;

  always_comb begin
    count_next = count;
    if (do_push && !do_pop) begin
      count_next = count + CW'(1);
    end else if (do_pop && !do_push) begin
      count_next = count - CW'(1);
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
      full   <= 1'b0;
      empty  <= 1'b1;
    end else begin
      if (do_push) wr_ptr <= (wr_ptr == last_ptr) ? '0 : wr_ptr + PW'(1);
      if (do_pop)  rd_ptr <= (rd_ptr == last_ptr) ? '0 : rd_ptr + PW'(1);
      count <= count_next;
      full  <= (count_next == CW'(DEPTH));
      empty <= (count_next == '0);
    end
  end

  always_ff @(posedge clk) begin
    if (do_push) mem[wr_ptr] <= din;
  end

  assign dout = mem[rd_ptr]; // head, valid when !empty

endmodule

`default_nettype wire

// ==== verification/b2s_rd_assert.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "b2s_defines.svh"

module b2s_rd_assert
  import axi_types_pkg::*;
(
  input wire  clk,
  input wire  reset,
  input wire  s_arvalid,
  input wire  s_arready,
  input s_r_t s_r,
  input wire  s_rvalid,
  input wire  s_rready,
  input wire  m_arvalid,
  input wire  m_arready,
  input wire  [$clog2(`B2S_DATA_DEPTH + 1)-1:0] credit_cnt
);

  m_arvalid_hold: assert property (@(posedge clk) disable iff (reset)
      m_arvalid && !m_arready |=> m_arvalid)
    else $error("m_arvalid dropped before m_arready");

  s_r_hold: assert property (@(posedge clk) disable iff (reset)
      s_rvalid && !s_rready |=> s_rvalid && $stable(s_r))
    else $error("s_rvalid or s_r changed before s_rready");

  // retire pulse only while the burst is still offered
  s_arready_valid: assert property (@(posedge clk) disable iff (reset)
      s_arready |-> s_arvalid)
    else $error("s_arready high without s_arvalid");

  credit_max: assert property (@(posedge clk) disable iff (reset)
      32'(credit_cnt) <= `B2S_DATA_DEPTH)
    else $error("credit count above data FIFO depth");

endmodule

bind b2s_rd_top b2s_rd_assert assert0 (
  .clk(clk), .reset(reset),
  .s_arvalid(s_arvalid), .s_arready(s_arready),
  .s_r(s_r), .s_rvalid(s_rvalid), .s_rready(s_rready),
  .m_arvalid(m_arvalid), .m_arready(m_arready),
  .credit_cnt(dp0.credit_cnt)
);

`default_nettype wire

// ==== verification/b2s_rd_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "b2s_defines.svh"

module b2s_rd_tb
  import axi_types_pkg::*;
();

  localparam int max_tests = 32;
  localparam int ar_timeout = 2000;    // cycles
  localparam int drain_timeout = 8000;
  localparam logic [31:0] data_key = 32'h5a5a_0000;

  logic   clk = 1'b0;
  logic   reset;
  s_ar_t  s_ar;
  logic   s_arvalid;
  logic   s_arready;
  s_r_t   s_r;
  logic   s_rvalid;
  logic   s_rready = 1'b0;
  m_cmd_t m_cmd;
  logic   m_arvalid;
  logic   m_arready = 1'b0;
  m_rsp_t m_rsp = '0;
  logic   m_rvalid = 1'b0;

  // one entry per data file line
  logic [31:0] t_code [max_tests];
  logic [31:0] t_id [max_tests];
  logic [31:0] t_addr [max_tests];
  int          t_len [max_tests];
  int          t_mst [max_tests];
  int          t_sst [max_tests];
  int          n_lines = 0;

  s_r_t        exp_r [$];
  logic [31:0] exp_cmd [$];
  logic [31:0] pend_addr [$];     // master model keeps these in order
  int          pend_due [$];
  int          last_due = 0;
  int          cycle = 0;
  int          cmds_taken = 0;
  int          beats_taken = 0;
  int          ar_pulses = 0;
  int          m_stall = 0;       // percent
  int          s_stall = 0;
  integer      seed = 32'hafb6_4b2d;
  int          main_fails = 0;
  int          mon_fails = 0;
  logic        hung = 1'b0;
  logic        verdict_done = 1'b0;

  b2s_rd_top dut0 (
    .clk(clk), .reset(reset),
    .s_ar(s_ar), .s_arvalid(s_arvalid), .s_arready(s_arready),
    .s_r(s_r), .s_rvalid(s_rvalid), .s_rready(s_rready),
    .m_cmd(m_cmd), .m_arvalid(m_arvalid), .m_arready(m_arready),
    .m_rsp(m_rsp), .m_rvalid(m_rvalid)
  );

  always #20 clk = ~clk;

  task automatic compare_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual, inout int fails);
    if (expected !== actual) begin
      $display("[FAIL] t=%0t %s expected %h got %h", $time, name, expected, actual);
      fails++;
    end
  endtask

  task automatic report_error(input string what, inout int fails);
    $display("error at t=%0t: %s", $time, what);
    fails++;
  endtask

  // ##########################################################
  // master model and slave R checker
  // ##########################################################
  always @(posedge clk) begin : monitor
    s_r_t        exp_beat;
    logic [31:0] rsp_addr;
    int          due;
    int          rnd;
    if (reset) begin
      m_arready <= 1'b0;
      s_rready  <= 1'b0;
      m_rvalid  <= 1'b0;
    end else begin
      cycle = cycle + 1;
      if (m_arvalid && m_arready) begin
        if (exp_cmd.size() == 0) begin
          report_error("master command issued with none expected", mon_fails);
        end else begin
          compare_value("m_cmd.addr", exp_cmd.pop_front(), m_cmd.addr, mon_fails);
        end
        rnd = $unsigned($random(seed)) % 4;
        due = cycle + 1 + rnd;
        if (due <= last_due) due = last_due + 1; // keep responses in order
        last_due = due;
        pend_addr.push_back(m_cmd.addr);
        pend_due.push_back(due);
        cmds_taken++;
      end
      if (s_rvalid && s_rready) begin
        if (exp_r.size() == 0) begin
          report_error("R beat delivered with none expected", mon_fails);
        end else begin
          exp_beat = exp_r.pop_front();
          compare_value("s_r.data", exp_beat.data, s_r.data, mon_fails);
          compare_value("s_r.id", 32'(exp_beat.id), 32'(s_r.id), mon_fails);
          compare_value("s_r.last", 32'(exp_beat.last), 32'(s_r.last), mon_fails);
          compare_value("s_r.resp", 32'(exp_beat.resp), 32'(s_r.resp), mon_fails);
        end
        beats_taken++;
      end
      if (s_arready) ar_pulses++;
      compare_value("outstanding within depth", 32'd1,
                    32'((cmds_taken - beats_taken) <= `B2S_DATA_DEPTH), mon_fails);
      m_rvalid <= 1'b0;
      if (pend_due.size() != 0 && pend_due[0] <= cycle) begin
        rsp_addr = pend_addr.pop_front();
        void'(pend_due.pop_front());
        m_rsp    <= '{data: rsp_addr ^ data_key, resp: 2'b00};
        m_rvalid <= 1'b1;
      end
      rnd = $unsigned($random(seed)) % 100;
      m_arready <= (rnd >= m_stall);
      rnd = $unsigned($random(seed)) % 100;
      s_rready <= (rnd >= s_stall);
    end
  end

  task automatic issue_burst(input int idx);
    s_r_t        beat;
    logic [31:0] addr;
    int          k;
    int          waited;
    m_stall = t_mst[idx];
    s_stall = t_sst[idx];
    for (k = 0; k <= t_len[idx]; k++) begin
      addr = t_addr[idx] + 32'(k * `B2S_BEAT_BYTES);
      exp_cmd.push_back(addr);
      beat.data = addr ^ data_key;
      beat.resp = 2'b00;
      beat.id   = t_id[idx][`B2S_ID_W-1:0];
      beat.last = (k == t_len[idx]);
      exp_r.push_back(beat);
    end
    @(posedge clk);
    s_ar <= '{addr: t_addr[idx], len: 8'(t_len[idx]), id: t_id[idx][`B2S_ID_W-1:0]};
    s_arvalid <= 1'b1;
    waited = 0;
    do begin
      @(posedge clk);
      waited++;
    end while (!s_arready && waited < ar_timeout);
    s_arvalid <= 1'b0;
    if (!s_arready) begin
      report_error($sformatf("s_arready never came for burst id %0h", t_id[idx]), main_fails);
      hung = 1'b1;
    end
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    do begin
      @(posedge clk);
      waited++;
    end while ((exp_r.size() != 0 || exp_cmd.size() != 0) && waited < drain_timeout);
    if (exp_r.size() != 0 || exp_cmd.size() != 0) begin
      report_error($sformatf("R channel hung with %0d beats and %0d commands outstanding",
                             exp_r.size(), exp_cmd.size()), main_fails);
      hung = 1'b1;
    end
  endtask

  // ##########################################################
  // main sequence
  // ##########################################################
  initial begin : main
    logic [8*160-1:0] line_buf;
    logic [31:0]      f_code;
    logic [31:0]      f_id;
    logic [31:0]      f_addr;
    logic [31:0]      code;
    int               f_len;
    int               f_mst;
    int               f_sst;
    int               fd;
    int               n;
    int               i;
    int               nb;
    int               fails_before;
    int               pulses_before;
    int               tests_failed;
    reset = 1'b1;
    s_ar = '0;
    s_arvalid = 1'b0;
    tests_failed = 0;
    fd = $fopen("verification/b2s_rd_tests.txt", "r");
    if (fd == 0) begin
      report_error("cannot open verification/b2s_rd_tests.txt", main_fails);
    end else begin
      n = $fgets(line_buf, fd); // two column header lines
      n = $fgets(line_buf, fd);
      n = $fscanf(fd, "%h %h %h %d %d %d", f_code, f_id, f_addr, f_len, f_mst, f_sst);
      while (n == 6 && n_lines < max_tests) begin
        t_code[n_lines] = f_code;
        t_id[n_lines]   = f_id;
        t_addr[n_lines] = f_addr;
        t_len[n_lines]  = f_len;
        t_mst[n_lines]  = f_mst;
        t_sst[n_lines]  = f_sst;
        n_lines++;
        n = $fscanf(fd, "%h %h %h %d %d %d", f_code, f_id, f_addr, f_len, f_mst, f_sst);
      end
      $fclose(fd);
      if (n_lines == 0) report_error("no tests found in the data file", main_fails);
    end
    repeat (8) @(posedge clk);
    reset <= 1'b0;
    @(posedge clk);
    compare_value("m_arvalid", 32'd0, 32'(m_arvalid), main_fails);
    compare_value("s_arready", 32'd0, 32'(s_arready), main_fails);
    compare_value("s_rvalid", 32'd0, 32'(s_rvalid), main_fails);
    // lines with the same code go back to back as one test
    i = 0;
    while (i < n_lines && !hung) begin
      code = t_code[i];
      fails_before = main_fails + mon_fails;
      pulses_before = ar_pulses;
      nb = 0;
      while (i < n_lines && t_code[i] == code && !hung) begin
        issue_burst(i);
        i++;
        nb++;
      end
      if (!hung) wait_drain();
      if (!hung) begin
        compare_value("s_arready pulses", 32'(pulses_before + nb), 32'(ar_pulses), main_fails);
      end
      if (main_fails + mon_fails == fails_before) begin
        $display("test %0h: %0d burst(s) ok", code, nb);
      end else begin
        $display("test %0h: %0d burst(s) failed", code, nb);
        tests_failed++;
      end
    end
    $display("tests failed %0d, errors %0d, beats %0d, commands %0d",
             tests_failed, main_fails + mon_fails, beats_taken, cmds_taken);
    verdict_done = 1'b1;
    if (main_fails + mon_fails == 0 && !hung) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

  // run ended before the main sequence reached its verdict
  final begin
    if (!verdict_done) $display(">>> FAIL");
  end

endmodule

`default_nettype wire

// ==== verification/b2s_rd_tests.txt ====
code(hex) id(hex) start_addr(hex) len(beats-1,dec) m_arready_stall_pct s_rready_stall_pct
lines with the same code are issued back to back as one test
1 3 00001000 0 0 0
2 5 00002000 15 0 0
3 7 00003000 15 60 0
3 7 00003400 31 80 0
4 9 00004000 23 0 90
4 9 00004800 40 20 85
5 a 00005000 3 0 0
5 b 00005100 7 20 30
5 c 00005200 0 0 0
6 d 00006000 63 30 50
7 f fffffff0 7 0 0
8 2 00008000 255 10 20
9 1 00009000 1 0 0
9 6 00009100 1 0 0
9 e 00009200 9 40 40
a 4 0000a000 12 50 70
b 8 0000b000 0 90 90
